/* files.f */
design/soc_bus_pkg.sv
design/soc_periph_pkg.sv
design/wb_arbiter.sv
design/wb_slave_mux.sv
design/wb_ram.sv
design/wb_gpio.sv
design/soc_top.sv
verif/tb_soc_top.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator and run it from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_soc_top -o tb_soc_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* verif/tb_soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  localparam int unsigned n_cores   = 2;
  localparam int unsigned ram_words = 256;

  localparam logic [31:0] w0_adr   = 32'h1000_0040;
  localparam logic [31:0] w1_adr   = 32'h1000_0044;
  localparam logic [31:0] w2_adr   = 32'h1000_03fc;
  localparam logic [31:0] gpio_adr = 32'h3000_0000;

  typedef struct {
    string       name;
    int          core;
    bit          fetch;
    bit          write;
    logic [3:0]  be;
    logic [31:0] adr;
    logic [31:0] wdat;
    logic [31:0] exp;
    bit          chk;
    // issued in the same cycle as the next row
    bit          pair;
  } row_t;

  logic                                clk_i;
  logic                                rst_i;
  logic [n_cores-1:0]                  imem_stb_i;
  logic [n_cores-1:0][bus_adr_w-1:0]   imem_adr_i;
  logic [n_cores-1:0]                  dmem_stb_i;
  logic [n_cores-1:0]                  dmem_we_i;
  logic [n_cores-1:0][bus_sel_w-1:0]   dmem_be_i;
  logic [n_cores-1:0][bus_adr_w-1:0]   dmem_adr_i;
  logic [n_cores-1:0][bus_dat_w-1:0]   dmem_wdat_i;
  logic [n_cores-1:0]                  ack_o;
  logic [n_cores-1:0][bus_dat_w-1:0]   rdat_o;
  logic [gpio_w-1:0]                   gpi_i;
  logic [gpio_w-1:0]                   gpo_o;
  logic [gpio_w-1:0]                   gpoe_o;

  row_t        rows[$];
  logic [31:0] ram_model [int unsigned];
  logic [gpio_w-1:0] gpo_model;
  logic [gpio_w-1:0] gpoe_model;
  logic [gpio_w-1:0] gpi_val;
  logic [31:0] lcg_state = 32'hf75e;
  int          checks;
  int          errors;
  int          timeouts;

  soc_top #(
    .NUM_CORES ( n_cores   ),
    .RAM_DEPTH ( ram_words )
  ) uut (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .imem_stb_i  ( imem_stb_i  ),
    .imem_adr_i  ( imem_adr_i  ),
    .dmem_stb_i  ( dmem_stb_i  ),
    .dmem_we_i   ( dmem_we_i   ),
    .dmem_be_i   ( dmem_be_i   ),
    .dmem_adr_i  ( dmem_adr_i  ),
    .dmem_wdat_i ( dmem_wdat_i ),
    .ack_o       ( ack_o       ),
    .rdat_o      ( rdat_o      ),
    .gpi_i       ( gpi_i       ),
    .gpo_o       ( gpo_o       ),
    .gpoe_o      ( gpoe_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ##########################################################################
  // reference model of the memory map
  // ##########################################################################

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ram aliases every ram_words words
  function automatic int unsigned ram_key(logic [31:0] adr);
    int unsigned key;
    key = 32'(adr[15:2]);
    return key % ram_words;
  endfunction

  function automatic logic [31:0] model_read(logic [31:0] adr);
    logic [31:0] val;
    val = '0;
    if (adr[31:28] == region_ram_c) begin
      val = ram_model[ram_key(adr)];
    end else if (adr[31:28] == region_gpio_c) begin
      case (adr[15:0])
        gpio_out_ofs_c: val[gpio_w-1:0] = gpo_model;
        gpio_oe_ofs_c:  val[gpio_w-1:0] = gpoe_model;
        gpio_in_ofs_c:  val[gpio_w-1:0] = gpi_val;
        default:        val = '0;
      endcase
    end
    return val;
  endfunction

  function automatic void model_write(logic [31:0] adr, logic [3:0] be, logic [31:0] wdat);
    logic [31:0] word;
    if (adr[31:28] == region_ram_c) begin
      word = ram_model.exists(ram_key(adr)) ? ram_model[ram_key(adr)] : '0;
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          word[8*b +: 8] = wdat[8*b +: 8];
        end
      end
      ram_model[ram_key(adr)] = word;
    end else if (adr[31:28] == region_gpio_c && be[0]) begin
      if (adr[15:0] == gpio_out_ofs_c) begin
        gpo_model = wdat[gpio_w-1:0];
      end
      if (adr[15:0] == gpio_oe_ofs_c) begin
        gpoe_model = wdat[gpio_w-1:0];
      end
    end
  endfunction

  // expected data comes from the model as it stands when the row is added
  function automatic void add_row(string name, int core, bit fetch, bit write,
                                  logic [3:0] be, logic [31:0] adr,
                                  logic [31:0] wdat, bit pair);
    row_t r;
    r.name  = name;
    r.core  = core;
    r.fetch = fetch;
    r.write = write;
    r.be    = be;
    r.adr   = adr;
    r.wdat  = wdat;
    r.chk   = !write;
    r.exp   = write ? '0 : model_read(adr);
    r.pair  = pair;
    if (write) begin
      model_write(adr, be, wdat);
    end
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    logic [31:0] rnd;
    gpo_model  = '0;
    gpoe_model = '0;
    rnd        = next_random();
    gpi_val    = rnd[gpio_w-1:0];
    add_row("ram_wr_w0", 0, 0, 1, 4'hf, w0_adr, next_random(), 0);
    add_row("ram_rd_w0", 1, 0, 0, 4'hf, w0_adr, '0, 0);
    add_row("ram_wr_w1", 1, 0, 1, 4'hf, w1_adr, next_random(), 0);
    add_row("ram_be_lo", 0, 0, 1, 4'b0101, w1_adr, next_random(), 0);
    add_row("ram_be_hi", 1, 0, 1, 4'b1000, w1_adr, next_random(), 0);
    add_row("ram_rd_w1", 0, 0, 0, 4'hf, w1_adr, '0, 0);
    // fetch rows carry a stray data-side write in wdat
    add_row("fetch_w0", 0, 1, 0, 4'hf, w0_adr, next_random(), 0);
    add_row("fetch_w1", 1, 1, 0, 4'hf, w1_adr, next_random(), 0);
    add_row("rd_after_fetch", 1, 0, 0, 4'hf, w0_adr, '0, 0);
    add_row("gpo_wr", 0, 0, 1, 4'b0001, gpio_adr, next_random(), 0);
    add_row("gpoe_wr", 1, 0, 1, 4'hf, gpio_adr + 32'h4, next_random(), 0);
    add_row("gpo_wr_no_lane0", 0, 0, 1, 4'b1110, gpio_adr, next_random(), 0);
    add_row("gpo_rd", 1, 0, 0, 4'hf, gpio_adr, '0, 0);
    add_row("gpoe_rd", 0, 0, 0, 4'hf, gpio_adr + 32'h4, '0, 0);
    add_row("gpi_rd", 1, 0, 0, 4'hf, gpio_adr + 32'h8, '0, 0);
    add_row("gpio_hole_rd", 0, 0, 0, 4'hf, gpio_adr + 32'hc, '0, 0);
    add_row("pair_rd_w0", 0, 0, 0, 4'hf, w0_adr, '0, 1);
    add_row("pair_rd_gpo", 1, 0, 0, 4'hf, gpio_adr, '0, 0);
    add_row("pair_wr_w2", 0, 0, 1, 4'hf, w2_adr, next_random(), 1);
    add_row("pair_rd_w1", 1, 0, 0, 4'hf, w1_adr, '0, 0);
    add_row("ram_rd_w2", 1, 0, 0, 4'hf, w2_adr, '0, 0);
    add_row("unmapped_rd", 0, 0, 0, 4'hf, 32'h2000_0010, '0, 0);
    add_row("unmapped_rd_hi", 1, 0, 0, 4'hf, 32'hf000_0000, '0, 0);
  endfunction

  // ##########################################################################
  // bus driving and checking
  // ##########################################################################

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic drive_row(input row_t r);
    if (r.fetch) begin
      imem_stb_i[r.core]  = 1'b1;
      imem_adr_i[r.core]  = r.adr;
      // data side asks for a write elsewhere that the merge has to ignore
      dmem_we_i[r.core]   = 1'b1;
      dmem_be_i[r.core]   = 4'hf;
      dmem_adr_i[r.core]  = r.adr ^ 32'h4;
      dmem_wdat_i[r.core] = r.wdat;
    end else begin
      dmem_stb_i[r.core]  = 1'b1;
      dmem_we_i[r.core]   = r.write;
      dmem_be_i[r.core]   = r.be;
      dmem_adr_i[r.core]  = r.adr;
      dmem_wdat_i[r.core] = r.wdat;
    end
  endtask

  task automatic release_core(input int c);
    imem_stb_i[c] = 1'b0;
    dmem_stb_i[c] = 1'b0;
    dmem_we_i[c]  = 1'b0;
  endtask

  // count rows start together on their own cores
  task automatic issue_group(input int first, input int count);
    logic [1:0] pending;
    logic [1:0] acked;
    int         cycles;
    int         c;
    pending = '0;
    acked   = '0;
    for (int k = 0; k < count; k++) begin
      drive_row(rows[first + k]);
      pending[k] = 1'b1;
    end
    cycles = 0;
    while (pending != '0 && cycles < int'(bus_timeout_c)) begin
      @(negedge clk_i);
      for (int k = 0; k < count; k++) begin
        c = rows[first + k].core;
        if (pending[k] && ack_o[c]) begin
          if (rows[first + k].chk) begin
            check_value(rows[first + k].name, rows[first + k].exp, rdat_o[c]);
          end
          pending[k] = 1'b0;
          acked[k]   = 1'b1;
        end else if (!pending[k] && ack_o[c]) begin
          errors++;
          $display("second ack for test %s on core %0d", rows[first + k].name, c);
        end
      end
      @(posedge clk_i);
      #1;
      for (int k = 0; k < count; k++) begin
        if (acked[k]) begin
          release_core(rows[first + k].core);
          acked[k] = 1'b0;
        end
      end
      cycles++;
    end
    for (int k = 0; k < count; k++) begin
      if (pending[k]) begin
        timeouts++;
        $display("no ack within %0d cycles for test %s on core %0d",
                 bus_timeout_c, rows[first + k].name, rows[first + k].core);
        release_core(rows[first + k].core);
      end
    end
  endtask

  // no stray acks once every strobe is down
  task automatic expect_quiet(input int n_cycles);
    for (int k = 0; k < n_cycles; k++) begin
      @(negedge clk_i);
      check_value("idle_ack", 32'h0, 32'(ack_o));
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin : main
    int i;
    int n;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    rst_i       = 1'b1;
    imem_stb_i  = '0;
    imem_adr_i  = '0;
    dmem_stb_i  = '0;
    dmem_we_i   = '0;
    dmem_be_i   = '0;
    dmem_adr_i  = '0;
    dmem_wdat_i = '0;
    gpi_i       = '0;
    build_table();

    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("reset_ack", 32'h0, 32'(ack_o));
    check_value("reset_gpo", 32'h0, 32'(gpo_o));
    check_value("reset_gpoe", 32'h0, 32'(gpoe_o));

    // input pins settle through the synchronizer
    @(posedge clk_i);
    #1;
    gpi_i = gpi_val;
    repeat (2) @(posedge clk_i);
    #1;

    i = 0;
    while (i < rows.size()) begin
      n = (rows[i].pair && (i + 1) < rows.size()) ? 2 : 1;
      issue_group(i, n);
      expect_quiet(2);
      i += n;
    end

    check_value("gpo_pins", 32'(gpo_model), 32'(gpo_o));
    check_value("gpoe_pins", 32'(gpoe_model), 32'(gpoe_o));

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
  parameter int unsigned NUM_CORES = 4,
  parameter int unsigned RAM_DEPTH = soc_periph_pkg::ram_depth_default_c
) (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  // core instruction ports
  input  logic [NUM_CORES-1:0]                              imem_stb_i,
  input  logic [NUM_CORES-1:0][soc_bus_pkg::bus_adr_w-1:0]  imem_adr_i,
  // core data ports
  input  logic [NUM_CORES-1:0]                              dmem_stb_i,
  input  logic [NUM_CORES-1:0]                              dmem_we_i,
  input  logic [NUM_CORES-1:0][soc_bus_pkg::bus_sel_w-1:0]  dmem_be_i,
  input  logic [NUM_CORES-1:0][soc_bus_pkg::bus_adr_w-1:0]  dmem_adr_i,
  input  logic [NUM_CORES-1:0][soc_bus_pkg::bus_dat_w-1:0]  dmem_wdat_i,
  output logic [NUM_CORES-1:0]                              ack_o,
  output logic [NUM_CORES-1:0][soc_bus_pkg::bus_dat_w-1:0]  rdat_o,
  // gpio pins
  input  logic [soc_periph_pkg::gpio_w-1:0]                 gpi_i,
  output logic [soc_periph_pkg::gpio_w-1:0]                 gpo_o,
  output logic [soc_periph_pkg::gpio_w-1:0]                 gpoe_o
);

  import soc_bus_pkg::*;

  // shared bus after arbitration
  logic                 bus_stb;
  logic                 bus_we;
  logic [bus_sel_w-1:0] bus_be;
  wb_adr_u              bus_adr;
  logic [bus_dat_w-1:0] bus_wdat;
  logic                 bus_ack;
  logic [bus_dat_w-1:0] bus_rdat;

  // slave side
  logic                 ram_stb;
  logic                 ram_ack;
  logic [bus_dat_w-1:0] ram_rdat;
  logic                 gpio_stb;
  logic                 gpio_ack;
  logic [bus_dat_w-1:0] gpio_rdat;

  // ##########################################################################
  // masters
  // ##########################################################################

  wb_arbiter #(
    .NUM_CORES ( NUM_CORES )
  ) i_wb_arbiter (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .imem_stb_i  ( imem_stb_i  ),
    .imem_adr_i  ( imem_adr_i  ),
    .dmem_stb_i  ( dmem_stb_i  ),
    .dmem_we_i   ( dmem_we_i   ),
    .dmem_be_i   ( dmem_be_i   ),
    .dmem_adr_i  ( dmem_adr_i  ),
    .dmem_wdat_i ( dmem_wdat_i ),
    .ack_o       ( ack_o       ),
    .rdat_o      ( rdat_o      ),
    .bus_stb_o   ( bus_stb     ),
    .bus_we_o    ( bus_we      ),
    .bus_be_o    ( bus_be      ),
    .bus_adr_o   ( bus_adr     ),
    .bus_wdat_o  ( bus_wdat    ),
    .bus_ack_i   ( bus_ack     ),
    .bus_rdat_i  ( bus_rdat    )
  );

  // ##########################################################################
  // decode and slaves
  // ##########################################################################

  wb_slave_mux i_wb_slave_mux (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .bus_stb_i   ( bus_stb   ),
    .bus_adr_i   ( bus_adr   ),
    .bus_ack_o   ( bus_ack   ),
    .bus_rdat_o  ( bus_rdat  ),
    .ram_stb_o   ( ram_stb   ),
    .ram_ack_i   ( ram_ack   ),
    .ram_rdat_i  ( ram_rdat  ),
    .gpio_stb_o  ( gpio_stb  ),
    .gpio_ack_i  ( gpio_ack  ),
    .gpio_rdat_i ( gpio_rdat )
  );

  wb_ram #(
    .RAM_DEPTH ( RAM_DEPTH )
  ) i_wb_ram (
    .clk_i  ( clk_i    ),
    .rst_i  ( rst_i    ),
    .stb_i  ( ram_stb  ),
    .we_i   ( bus_we   ),
    .be_i   ( bus_be   ),
    .adr_i  ( bus_adr  ),
    .wdat_i ( bus_wdat ),
    .ack_o  ( ram_ack  ),
    .rdat_o ( ram_rdat )
  );

  wb_gpio i_wb_gpio (
    .clk_i  ( clk_i     ),
    .rst_i  ( rst_i     ),
    .stb_i  ( gpio_stb  ),
    .we_i   ( bus_we    ),
    .be_i   ( bus_be    ),
    .adr_i  ( bus_adr   ),
    .wdat_i ( bus_wdat  ),
    .ack_o  ( gpio_ack  ),
    .rdat_o ( gpio_rdat ),
    .gpi_i  ( gpi_i     ),
    .gpo_o  ( gpo_o     ),
    .gpoe_o ( gpoe_o    )
  );

endmodule

`default_nettype wire

/* design/wb_gpio.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_gpio (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              stb_i,
  input  logic                              we_i,
  input  logic [soc_bus_pkg::bus_sel_w-1:0] be_i,
  input  soc_bus_pkg::wb_adr_u              adr_i,
  input  logic [soc_bus_pkg::bus_dat_w-1:0] wdat_i,
  output logic                              ack_o,
  output logic [soc_bus_pkg::bus_dat_w-1:0] rdat_o,
  // pins
  input  logic [soc_periph_pkg::gpio_w-1:0] gpi_i,
  output logic [soc_periph_pkg::gpio_w-1:0] gpo_o,
  output logic [soc_periph_pkg::gpio_w-1:0] gpoe_o
);

  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  logic [gpio_w-1:0]    gpo_q;
  logic [gpio_w-1:0]    gpoe_q;
  logic [gpio_w-1:0]    gpi_meta_q;
  logic [gpio_w-1:0]    gpi_sync_q;
  logic                 ack_q;
  logic [bus_dat_w-1:0] rdat_d;
  logic [bus_dat_w-1:0] rdat_q;
  logic                 wr_en;

  // two flops against metastability on the pins
  always_ff @(posedge clk_i) begin
    gpi_meta_q <= gpi_i;
    gpi_sync_q <= gpi_meta_q;
  end

  // only lane 0 carries register bits
  assign wr_en = stb_i && we_i && !ack_q && be_i[0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpo_q  <= '0;
      gpoe_q <= '0;
    end else if (wr_en) begin
      if (adr_i.fld.offset == gpio_out_ofs_c) begin
        gpo_q <= wdat_i[gpio_w-1:0];
      end
      if (adr_i.fld.offset == gpio_oe_ofs_c) begin
        gpoe_q <= wdat_i[gpio_w-1:0];
      end
    end
  end

  // read mux, unknown offsets give zero
  always_comb begin
    rdat_d = '0;
    case (adr_i.fld.offset)
      gpio_out_ofs_c: rdat_d[gpio_w-1:0] = gpo_q;
      gpio_oe_ofs_c:  rdat_d[gpio_w-1:0] = gpoe_q;
      gpio_in_ofs_c:  rdat_d[gpio_w-1:0] = gpi_sync_q;
      default:        rdat_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      rdat_q <= rdat_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i & ~ack_q;
    end
  end

  assign ack_o  = ack_q;
  assign rdat_o = rdat_q;
  assign gpo_o  = gpo_q;
  assign gpoe_o = gpoe_q;

endmodule

`default_nettype wire

/* design/wb_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_ram #(
  parameter int unsigned RAM_DEPTH = soc_periph_pkg::ram_depth_default_c
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              stb_i,
  input  logic                              we_i,
  input  logic [soc_bus_pkg::bus_sel_w-1:0] be_i,
  input  soc_bus_pkg::wb_adr_u              adr_i,
  input  logic [soc_bus_pkg::bus_dat_w-1:0] wdat_i,
  output logic                              ack_o,
  output logic [soc_bus_pkg::bus_dat_w-1:0] rdat_o
);

  import soc_bus_pkg::*;

  localparam int unsigned AW = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

  logic [bus_dat_w-1:0] mem [RAM_DEPTH];
  logic [AW-1:0]        word_idx;
  logic                 ack_q;
  logic [bus_dat_w-1:0] rdat_q;

  // word index sits above the byte lane bits
  assign word_idx = adr_i.fld.offset[AW+1:2];

  // byte-lane writes, once per access
  always_ff @(posedge clk_i) begin
    if (stb_i && we_i && !ack_q) begin
      for (int b = 0; b < bus_sel_w; b++) begin
        if (be_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdat_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      rdat_q <= mem[word_idx];
    end
  end

  // ack drops for a cycle even if stb stays up
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i & ~ack_q;
    end
  end

  assign ack_o  = ack_q;
  assign rdat_o = rdat_q;

endmodule

`default_nettype wire

/* design/wb_slave_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_slave_mux (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // from the arbiter
  input  logic                              bus_stb_i,
  input  soc_bus_pkg::wb_adr_u              bus_adr_i,
  output logic                              bus_ack_o,
  output logic [soc_bus_pkg::bus_dat_w-1:0] bus_rdat_o,
  // ram slave
  output logic                              ram_stb_o,
  input  logic                              ram_ack_i,
  input  logic [soc_bus_pkg::bus_dat_w-1:0] ram_rdat_i,
  // gpio slave
  output logic                              gpio_stb_o,
  input  logic                              gpio_ack_i,
  input  logic [soc_bus_pkg::bus_dat_w-1:0] gpio_rdat_i
);

  import soc_bus_pkg::*;

  logic unm_stb;
  logic unm_ack_q;

  // region decode
  assign ram_stb_o  = bus_stb_i && (bus_adr_i.fld.region == region_ram_c);
  assign gpio_stb_o = bus_stb_i && (bus_adr_i.fld.region == region_gpio_c);
  assign unm_stb    = bus_stb_i && !ram_stb_o && !gpio_stb_o;

  // local answer for holes in the map with one pulse per access
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      unm_ack_q <= 1'b0;
    end else begin
      unm_ack_q <= unm_stb & ~unm_ack_q;
    end
  end

  assign bus_ack_o = ram_ack_i | gpio_ack_i | unm_ack_q;

  // data follows whichever slave acked and is zero otherwise
  assign bus_rdat_o = ram_ack_i  ? ram_rdat_i  :
                      gpio_ack_i ? gpio_rdat_i : '0;

  // the read data mux relies on a single answering slave
  a_one_slave : assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({ram_ack_i, gpio_ack_i, unm_ack_q}));

endmodule

`default_nettype wire

/* design/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
  parameter int unsigned NUM_CORES = 4
) (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  // per-core instruction and data ports
  input  logic [NUM_CORES-1:0]                              imem_stb_i,
  input  logic [NUM_CORES-1:0][soc_bus_pkg::bus_adr_w-1:0]  imem_adr_i,
  input  logic [NUM_CORES-1:0]                              dmem_stb_i,
  input  logic [NUM_CORES-1:0]                              dmem_we_i,
  input  logic [NUM_CORES-1:0][soc_bus_pkg::bus_sel_w-1:0]  dmem_be_i,
  input  logic [NUM_CORES-1:0][soc_bus_pkg::bus_adr_w-1:0]  dmem_adr_i,
  input  logic [NUM_CORES-1:0][soc_bus_pkg::bus_dat_w-1:0]  dmem_wdat_i,
  output logic [NUM_CORES-1:0]                              ack_o,
  output logic [NUM_CORES-1:0][soc_bus_pkg::bus_dat_w-1:0]  rdat_o,
  // shared bus
  output logic                                              bus_stb_o,
  output logic                                              bus_we_o,
  output logic [soc_bus_pkg::bus_sel_w-1:0]                 bus_be_o,
  output soc_bus_pkg::wb_adr_u                              bus_adr_o,
  output logic [soc_bus_pkg::bus_dat_w-1:0]                 bus_wdat_o,
  input  logic                                              bus_ack_i,
  input  logic [soc_bus_pkg::bus_dat_w-1:0]                 bus_rdat_i
);

  import soc_bus_pkg::*;

  localparam int unsigned IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

  logic [NUM_CORES-1:0]                req_stb;
  logic [NUM_CORES-1:0]                req_we;
  logic [NUM_CORES-1:0][bus_sel_w-1:0] req_be;
  logic [NUM_CORES-1:0][bus_adr_w-1:0] req_adr;

  logic             busy_q;
  logic [IDX_W-1:0] grant_q;
  logic [IDX_W-1:0] next_idx;

  // ##########################################################################
  // port merge and return path per core
  // ##########################################################################

  for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
    // a fetch wins the merge with a full word and no write
    assign req_stb[c] = imem_stb_i[c] | dmem_stb_i[c];
    assign req_we[c]  = imem_stb_i[c] ? 1'b0 : dmem_we_i[c];
    assign req_be[c]  = imem_stb_i[c] ? {bus_sel_w{1'b1}} : dmem_be_i[c];
    assign req_adr[c] = imem_stb_i[c] ? imem_adr_i[c] : dmem_adr_i[c];

    // only the granted core sees ack and data
    assign ack_o[c]  = busy_q && (grant_q == IDX_W'(c)) && bus_ack_i;
    assign rdat_o[c] = (busy_q && (grant_q == IDX_W'(c))) ? bus_rdat_i : '0;
  end

  // ##########################################################################
  // round-robin grant
  // ##########################################################################

  // first requester after the last one served
  always_comb begin
    int unsigned cand;
    next_idx = grant_q;
    for (int unsigned i = NUM_CORES; i >= 1; i--) begin
      cand = (int'(grant_q) + i) % NUM_CORES;
      if (req_stb[cand]) begin
        next_idx = IDX_W'(cand);
      end
    end
  end

  // reset pointer at the last core so core 0 goes first
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      grant_q <= IDX_W'(NUM_CORES - 1);
    end else if (busy_q) begin
      busy_q <= ~bus_ack_i;
    end else if (|req_stb) begin
      busy_q  <= 1'b1;
      grant_q <= next_idx;
    end
  end

  assign bus_stb_o     = busy_q & req_stb[grant_q];
  assign bus_we_o      = req_we[grant_q];
  assign bus_be_o      = req_be[grant_q];
  assign bus_adr_o.raw = req_adr[grant_q];
  assign bus_wdat_o    = dmem_wdat_i[grant_q];

  a_one_strobe_per_core : assert property (@(posedge clk_i) disable iff (rst_i)
    (imem_stb_i & dmem_stb_i) == '0);

  // the owner keeps its request still until the slave has answered
  a_grant_held : assert property (@(posedge clk_i) disable iff (rst_i)
    busy_q && !bus_ack_i |=> bus_stb_o && $stable({bus_we_o, bus_be_o, bus_adr_o.raw}));

endmodule

`default_nettype wire

/* design/soc_periph_pkg.sv */
`default_nettype none

package soc_periph_pkg;

  // pins on the gpio block
  localparam int unsigned gpio_w = 8;

  // gpio register offsets, byte addressed
  localparam logic [15:0] gpio_out_ofs_c = 16'h0000;
  localparam logic [15:0] gpio_oe_ofs_c  = 16'h0004;
  // read only, fed by the synchronizer
  localparam logic [15:0] gpio_in_ofs_c  = 16'h0008;

  // on-chip ram size in 32-bit words
  localparam int unsigned ram_depth_default_c = 2048;

endpackage

`default_nettype wire

/* design/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // ##########################################################################
  // shared bus geometry
  // ##########################################################################

  localparam int unsigned bus_adr_w = 32;
  localparam int unsigned bus_dat_w = 32;
  localparam int unsigned bus_sel_w = bus_dat_w / 8;

  // one byte address, seen either whole or split into decode fields
  typedef union packed {
    logic [bus_adr_w-1:0] raw;
    struct packed {
      // selects the slave
      logic [3:0]  region;
      logic [11:0] reserved;
      // byte offset inside the slave
      logic [15:0] offset;
    } fld;
  } wb_adr_u;

  // ##########################################################################
  // address map
  // ##########################################################################

  // regions 0, 2 and 4..15 are unmapped and read as zero
  localparam logic [3:0] region_ram_c  = 4'h1;
  localparam logic [3:0] region_gpio_c = 4'h3;

  // upper bound on cycles from strobe to ack, with every core contending
  localparam int unsigned bus_timeout_c = 64;

endpackage

`default_nettype wire
